//--- Makefile
# Verilator build for the fetch front end

VERILATOR := verilator
TOP       := fetch_tb
FILELIST  := fetch_sys.f
FLAGS     := --timing --assert --timescale 1ns/1ps
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := === PASS ===

.PHONY: all lint sim clean

all: sim

# Static checks only
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, then decide on the log contents
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- fetch_sys.f
logic/fetch_pkg.sv
logic/val_rdy_queue.sv
logic/inst_mem.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
sim/fetch_props.sv
sim/fetch_tb.sv

//--- logic/fetch_ctrl.sv
// Fetch controller
// Issues sequential reads tagged with the current epoch, bounds the
// number in flight, redirects on request and drops stale responses

`default_nettype none

module fetch_ctrl import fetch_pkg::*; #(
  parameter logic [addr_w-1:0] rst_addr      = '0,
  parameter int                max_in_flight = 4
) (
  input  logic              clk,
  input  logic              rst,
  // Redirect strobe from a later stage
  input  logic              redirect,
  input  logic [addr_w-1:0] redirect_target,
  // Memory request
  output logic              req_val,
  input  logic              req_rdy,
  output mem_req_t          req,
  // Memory response
  input  logic              resp_val,
  output logic              resp_rdy,
  input  mem_resp_t         resp,
  // Toward decode
  output logic              fd_val,
  input  logic              fd_rdy,
  output fd_msg_t           fd
);

  localparam int cnt_w = $clog2(max_in_flight + 1);

  logic              req_xfer;
  logic              resp_xfer;
  logic              active;
  logic [addr_w-1:0] pc;
  logic [addr_w-1:0] req_addr;
  logic [addr_w-1:0] pc_next;
  logic [tag_w-1:0]  epoch;
  logic [tag_w-1:0]  epoch_next;
  logic [cnt_w-1:0]  in_flight;
  logic              stale;

  assign req_xfer  = req_val && req_rdy;
  assign resp_xfer = resp_val && resp_rdy;

  // Goes high on the first cycle out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
    end else begin
      active <= 1'b1;
    end
  end

  // --------------------
  // Pc and epoch
  // --------------------

  // Redirect takes effect in its own cycle
  always_comb begin
    req_addr   = redirect ? redirect_target : pc;
    epoch_next = redirect ? epoch + tag_w'(1) : epoch;
    pc_next    = req_xfer ? req_addr + addr_w'(4) : req_addr;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= rst_addr;
      epoch <= '0;
    end else begin
      pc    <= pc_next;
      epoch <= epoch_next;
    end
  end

  // --------------------
  // Request
  // --------------------

  // Counts reads not yet answered, dropped ones included
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else if (req_xfer && !resp_xfer) begin
      in_flight <= in_flight + cnt_w'(1);
    end else if (resp_xfer && !req_xfer) begin
      in_flight <= in_flight - cnt_w'(1);
    end
  end

  assign req_val = active && (in_flight < cnt_w'(max_in_flight));

  // Read only, tag is the epoch of this cycle
  always_comb begin
    req.op   = mem_read;
    req.tag  = epoch_next;
    req.addr = req_addr;
    req.data = '0;
  end

  // --------------------
  // Response
  // --------------------

  // Older epoch, answer to a squashed path
  assign stale = (resp.tag != epoch);

  // Stale responses are drained, others pass straight through
  assign resp_rdy = stale || fd_rdy;
  assign fd_val   = resp_val && !stale;

  always_comb begin
    fd.pc   = resp.addr;
    fd.inst = resp.data;
  end

endmodule

`default_nettype wire

//--- logic/fetch_pkg.sv
// Fetch package
// Widths and message formats shared by the fetch front end,
// the instruction memory and the output side

`default_nettype none

package fetch_pkg;

  // --------------------
  // Widths
  // --------------------

  // Byte address
  localparam int addr_w = 32;
  // One instruction word
  localparam int inst_w = 32;
  // Opaque field, carries the fetch epoch
  localparam int tag_w  = 4;

  // --------------------
  // Memory messages
  // --------------------

  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_e;

  // Request, 69 bits
  typedef struct packed {
    mem_op_e           op;
    logic [tag_w-1:0]  tag;
    logic [addr_w-1:0] addr;
    logic [inst_w-1:0] data;
  } mem_req_t;

  // Response, echoes tag and address of its request
  typedef struct packed {
    mem_op_e           op;
    logic [tag_w-1:0]  tag;
    logic [addr_w-1:0] addr;
    logic [inst_w-1:0] data;
  } mem_resp_t;

  // --------------------
  // Fetch to decode
  // --------------------

  typedef struct packed {
    logic [addr_w-1:0] pc;
    logic [inst_w-1:0] inst;
  } fd_msg_t;

endpackage

`default_nettype wire

//--- logic/fetch_top.sv
// Fetch front end top level
// Fetch controller, instruction memory and the decode-side output queue

`default_nettype none

module fetch_top import fetch_pkg::*; #(
  parameter logic [addr_w-1:0] rst_addr      = '0,
  parameter int                max_in_flight = 4,
  parameter int                mem_words     = 256,
  parameter int                mem_latency   = 2,
  parameter int                resp_depth    = 4,
  parameter int                out_depth     = 2
) (
  input  logic              clk,
  input  logic              rst,
  // Program load
  input  logic              load_en,
  input  logic [addr_w-1:0] load_addr,
  input  logic [inst_w-1:0] load_data,
  // Redirect strobe
  input  logic              redirect,
  input  logic [addr_w-1:0] redirect_target,
  // Fetched pc and instruction
  output logic              out_val,
  input  logic              out_rdy,
  output fd_msg_t           out
);

  // --------------------
  // Internal channels
  // --------------------

  logic      req_val;
  logic      req_rdy;
  mem_req_t  req;
  logic      resp_val;
  logic      resp_rdy;
  mem_resp_t resp;
  logic      fd_val;
  logic      fd_rdy;
  fd_msg_t   fd;

  fetch_ctrl #(
    .rst_addr     (rst_addr),
    .max_in_flight(max_in_flight)
  ) ctrl (
    .clk            (clk),
    .rst            (rst),
    .redirect       (redirect),
    .redirect_target(redirect_target),
    .req_val        (req_val),
    .req_rdy        (req_rdy),
    .req            (req),
    .resp_val       (resp_val),
    .resp_rdy       (resp_rdy),
    .resp           (resp),
    .fd_val         (fd_val),
    .fd_rdy         (fd_rdy),
    .fd             (fd)
  );

  inst_mem #(
    .mem_words  (mem_words),
    .mem_latency(mem_latency),
    .resp_depth (resp_depth)
  ) imem (
    .clk      (clk),
    .rst      (rst),
    .load_en  (load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  // Decouples decode back-pressure from the memory response path
  val_rdy_queue #(
    .depth    (out_depth),
    .payload_t(fd_msg_t)
  ) out_q (
    .clk    (clk),
    .rst    (rst),
    .in_val (fd_val),
    .in_rdy (fd_rdy),
    .in     (fd),
    .out_val(out_val),
    .out_rdy(out_rdy),
    .out    (out),
    .count  ()
  );

endmodule

`default_nettype wire

//--- logic/inst_mem.sv
// Instruction memory model
// Word array with a load port, a fixed-latency read pipeline and
// a response queue; credit logic keeps the pipeline from ever stalling

`default_nettype none

module inst_mem import fetch_pkg::*; #(
  parameter int mem_words   = 256,
  parameter int mem_latency = 2,
  parameter int resp_depth  = 4
) (
  input  logic              clk,
  input  logic              rst,
  // Load port, load_addr is a byte address
  input  logic              load_en,
  input  logic [addr_w-1:0] load_addr,
  input  logic [inst_w-1:0] load_data,
  // Request channel
  input  logic              req_val,
  output logic              req_rdy,
  input  mem_req_t          req,
  // Response channel
  output logic              resp_val,
  input  logic              resp_rdy,
  output mem_resp_t         resp
);

  localparam int idx_w  = (mem_words > 1) ? $clog2(mem_words) : 1;
  localparam int qcnt_w = $clog2(resp_depth + 1);
  localparam int occ_w  = $clog2(mem_latency + resp_depth + 1);

  logic [inst_w-1:0]      words [mem_words];
  logic                   req_xfer;
  mem_resp_t              rd_msg;
  logic [mem_latency-1:0] pipe_val;
  mem_resp_t              pipe_msg [mem_latency];
  logic [occ_w-1:0]       pipe_cnt;
  logic [qcnt_w-1:0]      q_count;
  logic [occ_w-1:0]       occupancy;

  // --------------------
  // Storage
  // --------------------

  // Word part of the byte address selects the entry
  always_ff @(posedge clk) begin
    if (load_en) begin
      words[load_addr[idx_w+1:2]] <= load_data;
    end
  end

  assign req_xfer = req_val && req_rdy;

  // Array read at issue, echo op, tag and address
  always_comb begin
    rd_msg.op   = req.op;
    rd_msg.tag  = req.tag;
    rd_msg.addr = req.addr;
    rd_msg.data = words[req.addr[idx_w+1:2]];
  end

  // --------------------
  // Read pipeline
  // --------------------

  // Valid bits shift one stage per cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      pipe_val <= '0;
    end else begin
      pipe_val[0] <= req_xfer;
      for (int i = 1; i < mem_latency; i++) begin
        pipe_val[i] <= pipe_val[i-1];
      end
    end
  end

  // Payload follows its valid bit
  always_ff @(posedge clk) begin
    pipe_msg[0] <= rd_msg;
    for (int i = 1; i < mem_latency; i++) begin
      pipe_msg[i] <= pipe_msg[i-1];
    end
  end

  // --------------------
  // Credit
  // --------------------

  // Reads in the pipeline
  always_comb begin
    pipe_cnt = '0;
    for (int i = 0; i < mem_latency; i++) begin
      pipe_cnt = pipe_cnt + occ_w'(pipe_val[i]);
    end
  end

  // Every accepted read owns a queue slot until it is popped
  assign occupancy = pipe_cnt + occ_w'(q_count);
  assign req_rdy   = (occupancy < occ_w'(resp_depth));

  // Last stage writes the queue, space is already reserved
  val_rdy_queue #(
    .depth    (resp_depth),
    .payload_t(mem_resp_t)
  ) resp_q (
    .clk    (clk),
    .rst    (rst),
    .in_val (pipe_val[mem_latency-1]),
    .in_rdy (),
    .in     (pipe_msg[mem_latency-1]),
    .out_val(resp_val),
    .out_rdy(resp_rdy),
    .out    (resp),
    .count  (q_count)
  );

endmodule

`default_nettype wire

//--- logic/val_rdy_queue.sv
// Val/rdy queue
// Circular FIFO with read and write pointers and an occupancy count
// Payload type is chosen by the instantiating module

`default_nettype none

module val_rdy_queue #(
  parameter int  depth     = 2,
  parameter type payload_t = logic [31:0]
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_val,
  output logic                         in_rdy,
  input  payload_t                     in,
  output logic                         out_val,
  input  logic                         out_rdy,
  output payload_t                     out,
  output logic [$clog2(depth+1)-1:0]   count
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         slots [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic             push;
  logic             pop;

  // Pointer wrap, depth need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(depth - 1)) begin
      return '0;
    end
    return p + ptr_w'(1);
  endfunction

  // --------------------
  // Handshakes
  // --------------------

  assign push    = in_val && in_rdy;
  assign pop     = out_val && out_rdy;
  // Full blocks the input, empty hides the output
  assign in_rdy  = (count != cnt_w'(depth));
  assign out_val = (count != '0);
  // Head entry, no bypass from the input
  assign out     = slots[rd_ptr];

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   count <= count + cnt_w'(1);
        2'b01:   count <= count - cnt_w'(1);
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      slots[wr_ptr] <= in;
    end
  end

endmodule

`default_nettype wire

//--- sim/fetch_props.sv
// Fetch controller properties
// In-flight bound, request stability under stall, stale response drops

`default_nettype none

module fetch_props import fetch_pkg::*; #(
  parameter int max_in_flight = 4
) (
  input logic                               clk,
  input logic                               rst,
  input logic                               redirect,
  input logic                               req_val,
  input logic                               req_rdy,
  input mem_req_t                           req,
  input logic                               resp_val,
  input mem_resp_t                          resp,
  input logic                               fd_val,
  input logic [$clog2(max_in_flight+1)-1:0] in_flight
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int cnt_w = $clog2(max_in_flight + 1);

  // Epoch rebuilt from the redirect strobes alone
  logic [tag_w-1:0] seen_epoch;

  always_ff @(posedge clk) begin
    if (rst) begin
      seen_epoch <= '0;
    end else if (redirect) begin
      seen_epoch <= seen_epoch + tag_w'(1);
    end
  end

  // --------------------
  // Request side
  // --------------------

  in_flight_bound: assert property (@(posedge clk) disable iff (rst)
    in_flight <= cnt_w'(max_in_flight))
    else $error("in-flight count above the limit");

  // Only a redirect may change a waiting request
  req_stable: assert property (@(posedge clk) disable iff (rst)
    req_val && !req_rdy |=>
      redirect || (req_val && $stable(req.addr) && $stable(req.tag)))
    else $error("stalled request changed its address or tag");

  // --------------------
  // Response side
  // --------------------

  stale_dropped: assert property (@(posedge clk) disable iff (rst)
    resp_val && (resp.tag != seen_epoch) |-> !fd_val)
    else $error("response of an older epoch reached decode");

endmodule

bind fetch_ctrl fetch_props #(
  .max_in_flight(max_in_flight)
) props (
  .clk      (clk),
  .rst      (rst),
  .redirect (redirect),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .req      (req),
  .resp_val (resp_val),
  .resp     (resp),
  .fd_val   (fd_val),
  .in_flight(in_flight)
);

`default_nettype wire

//--- sim/fetch_tb.sv
// Fetch front end testbench
// Loads a random program, fetches under random back-pressure and
// redirects, checks every output against a reference model

`default_nettype none

module fetch_tb import fetch_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // --------------------
  // Configuration
  // --------------------

  localparam logic [addr_w-1:0] rst_addr = 32'h0000_0100;
  localparam int max_in_flight = 6;
  localparam int mem_words     = 256;
  localparam int mem_latency   = 3;
  localparam int resp_depth    = 4;
  localparam int out_depth     = 2;
  localparam int idx_w         = $clog2(mem_words);
  localparam int rst_cycles    = 3;

  // Checked outputs per phase plus what an old path may still deliver
  localparam int seq_outputs   = 40 + 30 + 30 + 40;
  localparam int num_redirects = 5;
  localparam int old_outputs   = num_redirects * (max_in_flight + resp_depth + out_depth);
  localparam int cycle_limit   = (seq_outputs + old_outputs) * (mem_latency + 4)
                                 + mem_words + rst_cycles;

  logic              clk;
  logic              rst;
  logic              load_en;
  logic [addr_w-1:0] load_addr;
  logic [inst_w-1:0] load_data;
  logic              redirect;
  logic [addr_w-1:0] redirect_target;
  logic              out_val;
  logic              out_rdy;
  fd_msg_t           out_msg;

  // Program copy and checker state
  logic [inst_w-1:0] prog [mem_words];
  int                seed;
  int                cycles = 0;
  int                seq_count;
  int                total_outs = 0;
  logic [addr_w-1:0] exp_pc;
  logic              pending;
  logic [addr_w-1:0] pending_target;

  fetch_top #(
    .rst_addr     (rst_addr),
    .max_in_flight(max_in_flight),
    .mem_words    (mem_words),
    .mem_latency  (mem_latency),
    .resp_depth   (resp_depth),
    .out_depth    (out_depth)
  ) UUT (
    .clk            (clk),
    .rst            (rst),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .redirect       (redirect),
    .redirect_target(redirect_target),
    .out_val        (out_val),
    .out_rdy        (out_rdy),
    .out            (out_msg)
  );

  always #50 clk = ~clk;

  // Word at pc/4 of the loaded program
  function automatic logic [inst_w-1:0] expected_inst(input logic [addr_w-1:0] pc);
    return prog[pc[idx_w+1:2]];
  endfunction

  task automatic fail_value(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
    $display("=== FAIL ===");
    $fatal(1, "output mismatch");
  endtask

  // Next falling edge and a new out_rdy draw
  task automatic step();
    @(negedge clk);
    out_rdy = ($random(seed) % 4) != 0;
  endtask

  task automatic wait_outputs(input int n);
    while (pending || seq_count < n) begin
      step();
    end
  endtask

  // The last strobed target is the one to expect
  task automatic redirect_to(input logic [addr_w-1:0] target);
    step();
    redirect        = 1'b1;
    redirect_target = target;
    pending         = 1'b1;
    pending_target  = target;
    seq_count       = 0;
  endtask

  task automatic end_redirect();
    step();
    redirect = 1'b0;
  endtask

  // --------------------
  // Stimulus
  // --------------------

  initial begin
    logic [inst_w-1:0] word;
    clk             = 1'b0;
    rst             = 1'b1;
    load_en         = 1'b0;
    load_addr       = '0;
    load_data       = '0;
    redirect        = 1'b0;
    redirect_target = '0;
    out_rdy         = 1'b0;
    seed            = 80933;
    seq_count       = 0;
    exp_pc          = rst_addr;
    pending         = 1'b0;
    pending_target  = '0;
    // Program load while fetch sits in reset
    for (int i = 0; i < mem_words; i++) begin
      @(negedge clk);
      assert (out_val == 1'b0) else fail_value("out_val", 32'd0, 32'(out_val));
      word            = $random(seed);
      load_en         = 1'b1;
      load_addr       = addr_w'(i * 4);
      load_data       = word;
      prog[idx_w'(i)] = word;
    end
    @(negedge clk);
    load_en = 1'b0;
    repeat (rst_cycles) @(negedge clk);
    rst = 1'b0;
    // Straight-line fetch under back-pressure
    wait_outputs(40);
    // Single redirects behind and ahead of the stream
    redirect_to(32'h0000_0040);
    end_redirect();
    wait_outputs(30);
    redirect_to(32'h0000_0200);
    end_redirect();
    wait_outputs(30);
    // Three in a row and only the last survives
    redirect_to(32'h0000_0300);
    redirect_to(32'h0000_0080);
    redirect_to(32'h0000_0010);
    end_redirect();
    wait_outputs(40);
    $display("%0d outputs checked", total_outs);
    $display("=== PASS ===");
    $finish;
  end

  // --------------------
  // Checker
  // --------------------

  always @(posedge clk) begin
    if (!rst && out_val && out_rdy) begin
      // Old path may run on until the new target shows up
      if (pending && out_msg.pc == pending_target) begin
        pending   = 1'b0;
        exp_pc    = pending_target;
        seq_count = 0;
      end
      assert (out_msg.pc == exp_pc) else fail_value("out.pc", exp_pc, out_msg.pc);
      assert (out_msg.inst == expected_inst(out_msg.pc))
        else fail_value("out.inst", expected_inst(out_msg.pc), out_msg.inst);
      exp_pc = exp_pc + addr_w'(4);
      if (!pending) begin
        seq_count++;
      end
      total_outs++;
    end
  end

  // Stall guard
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the output stream stalled", cycles);
      $display("=== FAIL ===");
      $fatal(1, "timeout");
    end
  end

endmodule

`default_nettype wire
